/* Makefile */
# Verilator flow for the rename core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module rename_core

sim:
	verilator --binary --timing -f src.f --top-module rename_core_tb
	@out="$$(./obj_dir/Vrename_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* logic/exec_stage.sv */
// execute stage with the physical register file, alu and done report to the rob
`timescale 1ns/1ps

module exec_stage import rename_pkg::*; (
	input  logic       clk,
	input  logic       rst_n_i,
	issue_if.exec_mp   issue,
	// completion to rob
	output logic       done_valid_o,
	output rob_idx_t   done_idx_o,
	output data_t      done_value_o
);

	data_t prf [PREG_NUM]; // physical register file
	data_t opa;
	data_t opb;
	data_t imm_ext;
	data_t alu_res;

	// ==================================================
	// operand read
	// ==================================================
	// async read sees a write from the last edge
	assign opa     = issue.srca_zero ? '0 : prf[issue.srca_preg];
	assign opb     = issue.srcb_zero ? '0 : prf[issue.srcb_preg];
	assign imm_ext = {{(DATA_W - IMM_W){1'b0}}, issue.imm}; // zero extend

	// ==================================================
	// alu
	// ==================================================
	always_comb begin
		case (issue.op)
			OP_ADD:  alu_res = opa + opb; // wraps
			OP_SUB:  alu_res = opa - opb;
			OP_AND:  alu_res = opa & opb;
			OP_OR:   alu_res = opa | opb;
			OP_XOR:  alu_res = opa ^ opb;
			OP_LDI:  alu_res = imm_ext;
			default: alu_res = '0;
		endcase
	end

	// ==================================================
	// writeback
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < PREG_NUM; i++) begin
				prf[i] <= '0;
			end
		end else if (issue.valid && issue.has_dest) begin
			prf[issue.dest_preg] <= alu_res;
		end
	end

	// done leaves in the issue cycle and lands in the rob with the prf write
	assign done_valid_o = issue.valid;
	assign done_idx_o   = issue.rob_idx;
	assign done_value_o = alu_res; // rob zeroes it for r31 dests

endmodule : exec_stage

/* logic/free_list.sv */
// circular list of free physical tags, popped at rename and refilled by the rob at retire
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  alloc_i,         // pop head
	input  logic  release_valid_i, // push at tail
	input  preg_t release_preg_i,
	output preg_t free_preg_o,
	output logic  free_empty_o
);

	preg_t   fl_mem [FREE_NUM];
	fl_ptr_t fl_head;
	fl_ptr_t fl_tail;
	fl_cnt_t fl_count;
	logic    do_pop;

	assign free_preg_o  = fl_mem[fl_head]; // next tag handed out
	assign free_empty_o = (fl_count == '0);
	assign do_pop       = alloc_i && !free_empty_o;

	// tags 32..47 are free after reset, 0..31 sit in the map table
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < FREE_NUM; i++) begin
				fl_mem[i] <= preg_t'(AREG_NUM + i);
			end
			fl_head  <= '0;
			fl_tail  <= '0;
			fl_count <= fl_cnt_t'(FREE_NUM);
		end else begin
			if (release_valid_i) begin
				fl_mem[fl_tail] <= release_preg_i;
				fl_tail <= (fl_tail == fl_ptr_t'(FREE_NUM - 1)) ? '0 : fl_tail + 1'b1;
			end
			if (do_pop) begin
				fl_head <= (fl_head == fl_ptr_t'(FREE_NUM - 1)) ? '0 : fl_head + 1'b1;
			end
			// both on one edge leaves the count alone
			case ({release_valid_i, do_pop})
				2'b10:   fl_count <= fl_count + 1'b1;
				2'b01:   fl_count <= fl_count - 1'b1;
				default: fl_count <= fl_count;
			endcase
		end
	end

endmodule : free_list

/* logic/pipe_ifs.sv */
// stage-to-stage bundles of the core, issue from rename to execute and rob allocation at rename
`timescale 1ns/1ps

// ==================================================
// renamed instruction, rename -> execute
// ==================================================
interface issue_if import rename_pkg::*; ();
	logic     valid;     // one instr per cycle, no ready
	alu_op_e  op;
	preg_t    dest_preg; // new tag for the dest
	preg_t    srca_preg;
	preg_t    srcb_preg;
	logic     srca_zero; // source a is the zero reg
	logic     srcb_zero;
	imm_t     imm;
	rob_idx_t rob_idx;   // slot to mark done
	logic     has_dest;  // write the prf

	modport rename_mp (output valid, op, dest_preg, srca_preg, srcb_preg,
		srca_zero, srcb_zero, imm, rob_idx, has_dest);
	modport exec_mp (input valid, op, dest_preg, srca_preg, srcb_preg,
		srca_zero, srcb_zero, imm, rob_idx, has_dest);
endinterface : issue_if

// ==================================================
// rob allocation, rename <-> rob
// ==================================================
interface rob_alloc_if import rename_pkg::*; ();
	logic     valid;     // allocate on every edge it is high
	areg_t    areg_dest;
	preg_t    new_preg;
	preg_t    old_preg;  // freed at retire
	logic     has_dest;
	logic     full;
	rob_idx_t tail_idx;  // slot the next allocation takes

	modport rename_mp (output valid, areg_dest, new_preg, old_preg, has_dest,
		input full, tail_idx);
	modport rob_mp (input valid, areg_dest, new_preg, old_preg, has_dest,
		output full, tail_idx);
endinterface : rob_alloc_if

/* logic/rename_core.sv */
// top level of the in-order rename core, joins rename, execute and rob behind plain valid/ready ports
`timescale 1ns/1ps

module rename_core import rename_pkg::*; (
	input  logic    clk,
	input  logic    rst_n_i,
	// decoded instruction in
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  alu_op_e in_op_i,
	input  areg_t   in_dest_i,
	input  areg_t   in_srca_i,
	input  areg_t   in_srcb_i,
	input  imm_t    in_imm_i,
	// retired result out
	output logic    retire_valid_o,
	input  logic    retire_ready_i,
	output areg_t   retire_dest_o,
	output data_t   retire_value_o
);

	// ==================================================
	// stage links
	// ==================================================
	issue_if     issue_bus ();
	rob_alloc_if alloc_bus ();

	logic     done_valid;    // exec -> rob
	rob_idx_t done_idx;
	data_t    done_value;
	logic     release_valid; // rob -> free list
	preg_t    release_preg;

	rename_stage rename_stage_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.in_valid_i      (in_valid_i),
		.in_op_i         (in_op_i),
		.in_dest_i       (in_dest_i),
		.in_srca_i       (in_srca_i),
		.in_srcb_i       (in_srcb_i),
		.in_imm_i        (in_imm_i),
		.in_ready_o      (in_ready_o),
		.release_valid_i (release_valid),
		.release_preg_i  (release_preg),
		.issue           (issue_bus.rename_mp),
		.alloc           (alloc_bus.rename_mp)
	);

	exec_stage exec_stage_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.issue        (issue_bus.exec_mp),
		.done_valid_o (done_valid),
		.done_idx_o   (done_idx),
		.done_value_o (done_value)
	);

	rob rob_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.alloc           (alloc_bus.rob_mp),
		.done_valid_i    (done_valid),
		.done_idx_i      (done_idx),
		.done_value_i    (done_value),
		.retire_valid_o  (retire_valid_o),
		.retire_ready_i  (retire_ready_i),
		.retire_dest_o   (retire_dest_o),
		.retire_value_o  (retire_value_o),
		.release_valid_o (release_valid),
		.release_preg_o  (release_preg)
	);

endmodule : rename_core

/* logic/rename_pkg.sv */
// shared sizes, index types and alu opcodes of the rename core, imported by every rtl block
package rename_pkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int DATA_W    = 32;                  // datapath width
	localparam int AREG_NUM  = 32;                  // architectural regs
	localparam int ZERO_REG  = 31;                  // hardwired zero, never renamed
	localparam int PREG_NUM  = 48;                  // physical regs
	localparam int FREE_NUM  = PREG_NUM - AREG_NUM; // spare tags after reset
	localparam int ROB_DEPTH = 32;
	localparam int IMM_W     = 16;

	// index widths
	localparam int AREG_W   = $clog2(AREG_NUM);
	localparam int PREG_W   = $clog2(PREG_NUM);
	localparam int ROB_W    = $clog2(ROB_DEPTH);
	localparam int FL_PTR_W = $clog2(FREE_NUM);

	// ==================================================
	// types
	// ==================================================
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [AREG_W-1:0]   areg_t;
	typedef logic [PREG_W-1:0]   preg_t;
	typedef logic [ROB_W-1:0]    rob_idx_t;
	typedef logic [IMM_W-1:0]    imm_t;
	typedef logic [ROB_W:0]      rob_cnt_t;   // one extra bit so full fits
	typedef logic [FL_PTR_W-1:0] fl_ptr_t;
	typedef logic [FL_PTR_W:0]   fl_cnt_t;

	// alu ops, all arithmetic wraps mod 2^32
	typedef enum logic [2:0] {
		OP_ADD = 3'd0, // a + b
		OP_SUB = 3'd1, // a - b
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_LDI = 3'd5  // zero-extended immediate
	} alu_op_e;

endpackage : rename_pkg

/* logic/rename_stage.sv */
// rename stage, map table lookup and update, accept rule, rob allocation and issue register
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
	input  logic           clk,
	input  logic           rst_n_i,
	// decoded instruction in
	input  logic           in_valid_i,
	input  alu_op_e        in_op_i,
	input  areg_t          in_dest_i,
	input  areg_t          in_srca_i,
	input  areg_t          in_srcb_i,
	input  imm_t           in_imm_i,
	output logic           in_ready_o,
	// freed tags from retire
	input  logic           release_valid_i,
	input  preg_t          release_preg_i,
	issue_if.rename_mp     issue,
	rob_alloc_if.rename_mp alloc
);

	preg_t map_tbl [AREG_NUM]; // arch -> phys
	preg_t free_preg;
	logic  free_empty;
	logic  dest_real;          // dest gets a new tag
	logic  accept;
	logic  fl_alloc;

	// ==================================================
	// acceptance
	// ==================================================
	assign dest_real  = (in_dest_i != areg_t'(ZERO_REG));
	// zero-reg writes need a rob slot only
	assign in_ready_o = !alloc.full && (!free_empty || !dest_real);
	assign accept     = in_valid_i && in_ready_o;
	assign fl_alloc   = accept && dest_real;

	// rob slot for every accepted instr
	assign alloc.valid     = accept;
	assign alloc.areg_dest = in_dest_i;
	assign alloc.new_preg  = free_preg;
	assign alloc.old_preg  = map_tbl[in_dest_i]; // superseded tag
	assign alloc.has_dest  = dest_real;

	free_list free_list_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.alloc_i         (fl_alloc),
		.release_valid_i (release_valid_i),
		.release_preg_i  (release_preg_i),
		.free_preg_o     (free_preg),
		.free_empty_o    (free_empty)
	);

	// ==================================================
	// map table
	// ==================================================
	// identity after reset, sources below see the old entry on the update edge
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				map_tbl[i] <= preg_t'(i);
			end
		end else if (fl_alloc) begin
			map_tbl[in_dest_i] <= free_preg;
		end
	end

	// ==================================================
	// issue register
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			issue.op        <= in_op_i;
			issue.dest_preg <= alloc.new_preg;
			issue.srca_preg <= map_tbl[in_srca_i];
			issue.srcb_preg <= map_tbl[in_srcb_i];
			issue.srca_zero <= (in_srca_i == areg_t'(ZERO_REG)); // read as zero
			issue.srcb_zero <= (in_srcb_i == areg_t'(ZERO_REG));
			issue.imm       <= in_imm_i;
			issue.rob_idx   <= alloc.tail_idx;
			issue.has_dest  <= alloc.has_dest;
		end
	end

endmodule : rename_stage

/* logic/rob.sv */
// reorder buffer, collects completions and retires in program order, freeing superseded tags
`timescale 1ns/1ps

module rob import rename_pkg::*; (
	input  logic           clk,
	input  logic           rst_n_i,
	rob_alloc_if.rob_mp    alloc,
	// completion from execute
	input  logic           done_valid_i,
	input  rob_idx_t       done_idx_i,
	input  data_t          done_value_i,
	// retire port
	output logic           retire_valid_o,
	input  logic           retire_ready_i,
	output areg_t          retire_dest_o,
	output data_t          retire_value_o,
	// tag back to the free list
	output logic           release_valid_o,
	output preg_t          release_preg_o
);

	// entry fields
	areg_t                rob_dest     [ROB_DEPTH];
	preg_t                rob_old_preg [ROB_DEPTH];
	data_t                rob_value    [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] rob_has_dest;
	logic [ROB_DEPTH-1:0] rob_done;

	rob_idx_t rob_head; // oldest
	rob_idx_t rob_tail; // next free slot
	rob_cnt_t rob_count;
	logic     retire_fire;

	assign alloc.full     = (rob_count == rob_cnt_t'(ROB_DEPTH));
	assign alloc.tail_idx = rob_tail;

	// ==================================================
	// retire and release
	// ==================================================
	assign retire_valid_o  = rob_done[rob_head]; // cleared once the slot retires
	assign retire_fire     = retire_valid_o && retire_ready_i;
	assign retire_dest_o   = rob_dest[rob_head];
	assign retire_value_o  = rob_has_dest[rob_head] ? rob_value[rob_head] : '0;
	assign release_valid_o = retire_fire && rob_has_dest[rob_head];
	assign release_preg_o  = rob_old_preg[rob_head];

	// ==================================================
	// pointers and done bits
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rob_head  <= '0;
			rob_tail  <= '0;
			rob_count <= '0;
			rob_done  <= '0;
		end else begin
			if (alloc.valid) begin
				rob_done[rob_tail] <= 1'b0; // fresh slot
				rob_tail <= (rob_tail == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : rob_tail + 1'b1;
			end
			if (done_valid_i) begin
				rob_done[done_idx_i] <= 1'b1;
			end
			if (retire_fire) begin
				rob_done[rob_head] <= 1'b0;
				rob_head <= (rob_head == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : rob_head + 1'b1;
			end
			case ({alloc.valid, retire_fire})
				2'b10:   rob_count <= rob_count + 1'b1;
				2'b01:   rob_count <= rob_count - 1'b1;
				default: rob_count <= rob_count;
			endcase
		end
	end

	// entry payload, written at allocation and at completion
	always_ff @(posedge clk) begin
		if (alloc.valid) begin
			rob_dest[rob_tail]     <= alloc.areg_dest;
			rob_old_preg[rob_tail] <= alloc.old_preg;
			rob_has_dest[rob_tail] <= alloc.has_dest;
		end
		if (done_valid_i) begin
			rob_value[done_idx_i] <= done_value_i;
		end
	end

endmodule : rob

/* src.f */
logic/rename_pkg.sv
logic/pipe_ifs.sv
logic/free_list.sv
logic/rename_stage.sv
logic/exec_stage.sv
logic/rob.sv
logic/rename_core.sv
verif/rename_core_tb.sv

/* verif/rename_core_tb.sv */
// rename core testbench that runs an instruction table and checks each retirement in order
`timescale 1ns/1ps

module rename_core_tb import rename_pkg::*; ();

	logic    clk = 1'b0;
	logic    rst_n_i;
	logic    in_valid_i;
	logic    in_ready_o;
	alu_op_e in_op_i;
	areg_t   in_dest_i;
	areg_t   in_srca_i;
	areg_t   in_srcb_i;
	imm_t    in_imm_i;
	logic    retire_valid_o;
	logic    retire_ready_i;
	areg_t   retire_dest_o;
	data_t   retire_value_o;

	// stimulus table as parallel queues with one entry per row
	alu_op_e row_op [$];
	areg_t   row_dest [$];  // also the expected retire dest
	areg_t   row_srca [$];
	areg_t   row_srcb [$];
	imm_t    row_imm [$];
	data_t   row_value [$]; // expected retire value
	bit      row_stall [$]; // offered while retire is held low

	int          value_errors = 0;
	int          other_errors = 0;
	int          n_retired = 0;
	bit          hold_retire = 1'b0;
	logic [31:0] lfsr_state = 32'h329d;

	rename_core rename_core_inst (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.in_valid_i     (in_valid_i),
		.in_ready_o     (in_ready_o),
		.in_op_i        (in_op_i),
		.in_dest_i      (in_dest_i),
		.in_srca_i      (in_srca_i),
		.in_srcb_i      (in_srcb_i),
		.in_imm_i       (in_imm_i),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_dest_o  (retire_dest_o),
		.retire_value_o (retire_value_o)
	);

	always #20 clk = ~clk; // 40 ns period

	// ==================================================
	// helpers
	// ==================================================
	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic add_row(input alu_op_e op, input int dest, input int srca, input int srcb,
		input int imm, input data_t value, input int stall);
		row_op.push_back(op);
		row_dest.push_back(areg_t'(dest));
		row_srca.push_back(areg_t'(srca));
		row_srcb.push_back(areg_t'(srcb));
		row_imm.push_back(imm_t'(imm));
		row_value.push_back(value);
		row_stall.push_back(stall != 0);
	endtask

	// starts 2 ns after a rising edge and returns 2 ns after the accepting edge
	task automatic offer_row(input int i);
		int   waited;
		logic acc;
		in_valid_i = 1'b1;
		in_op_i    = row_op[i];
		in_dest_i  = row_dest[i];
		in_srca_i  = row_srca[i];
		in_srcb_i  = row_srcb[i];
		in_imm_i   = row_imm[i];
		waited     = 0;
		acc        = 1'b0;
		while (!acc) begin
			@(negedge clk); // handshake inputs settled here
			if (row_stall[i] && waited == 0) begin
				assert (in_ready_o) else begin
					$display("[FAIL] %0t ns in_ready_o: got %b expected 1 (row %0d)",
						$time, in_ready_o, i);
					value_errors++;
				end
			end
			acc = in_ready_o;
			waited++;
			@(posedge clk);
		end
		#2;
		in_valid_i = 1'b0;
	endtask

	// waits for n retirements and parks at a falling edge
	task automatic wait_retired(input int n);
		while (n_retired < n) begin
			@(posedge clk);
			#2;
		end
		@(negedge clk);
	endtask

	// free list is empty so a real dest must be refused
	task automatic check_full_stop(input int head_row);
		in_valid_i = 1'b0;
		in_dest_i  = areg_t'(1);
		repeat (2) @(negedge clk);
		assert (!in_ready_o) else begin
			$display("[FAIL] %0t ns in_ready_o: got %b expected 0", $time, in_ready_o);
			value_errors++;
		end
		// head row is long done and still waits for retire_ready_i
		assert (retire_valid_o) else begin
			$display("[FAIL] %0t ns retire_valid_o: got %b expected 1", $time, retire_valid_o);
			value_errors++;
		end
		assert (retire_dest_o == row_dest[head_row]) else begin
			$display("[FAIL] %0t ns retire_dest_o: got %0d expected %0d",
				$time, retire_dest_o, row_dest[head_row]);
			value_errors++;
		end
		@(posedge clk);
		#2;
	endtask

	// ==================================================
	// retire back-pressure
	// ==================================================
	always @(posedge clk) begin
		#2;
		if (hold_retire) begin
			retire_ready_i = 1'b0;
		end else begin
			retire_ready_i = lfsr_state[0]; // one bit per step
			lfsr_state = lfsr_step(lfsr_state);
		end
	end

	// ==================================================
	// retire checker
	// ==================================================
	always @(negedge clk) begin
		if (rst_n_i && retire_valid_o && retire_ready_i) begin
			assert (n_retired < row_op.size()) else begin
				$display("an extra retirement beyond the table was seen at %0t ns", $time);
				other_errors++;
			end
			if (n_retired < row_op.size()) begin
				assert (retire_dest_o == row_dest[n_retired]) else begin
					$display("[FAIL] %0t ns retire_dest_o: got %0d expected %0d",
						$time, retire_dest_o, row_dest[n_retired]);
					value_errors++;
				end
				assert (retire_value_o == row_value[n_retired]) else begin
					$display("[FAIL] %0t ns retire_value_o: got %h expected %h",
						$time, retire_value_o, row_value[n_retired]);
					value_errors++;
				end
			end
			n_retired++;
		end
	end

	// watchdog counted from reset release
	initial begin
		int limit;
		@(posedge rst_n_i);
		limit = 40 * row_op.size() + 200;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d rows retired",
			limit, n_retired, row_op.size());
		$display("Result: FAILED");
		$finish;
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		rst_n_i        = 1'b0;
		in_valid_i     = 1'b0;
		in_op_i        = OP_ADD;
		in_dest_i      = '0;
		in_srca_i      = '0;
		in_srcb_i      = '0;
		in_imm_i       = '0;
		retire_ready_i = 1'b0;

		// op, dest, srca, srcb, imm, expected value, stall
		add_row(OP_LDI,  1,  0,  0, 16'h1234, 32'h0000_1234, 0); // alu chain
		add_row(OP_LDI,  2,  0,  0, 16'hffff, 32'h0000_ffff, 0);
		add_row(OP_ADD,  3,  1,  2, 0, 32'h0001_1233, 0);
		add_row(OP_SUB,  4,  1,  2, 0, 32'hffff_1235, 0);          // wraps below zero
		add_row(OP_AND,  5,  1,  2, 0, 32'h0000_1234, 0);
		add_row(OP_OR,   6,  1,  2, 0, 32'h0000_ffff, 0);
		add_row(OP_XOR,  7,  1,  2, 0, 32'h0000_edcb, 0);
		add_row(OP_SUB,  8,  0,  1, 0, 32'hffff_edcc, 0);
		add_row(OP_LDI,  9,  0,  0, 16'h0005, 32'h0000_0005, 0); // dependent chain
		add_row(OP_ADD,  9,  9,  9, 0, 32'h0000_000a, 0);
		add_row(OP_ADD, 10,  9,  9, 0, 32'h0000_0014, 0);
		add_row(OP_SUB,  9, 10,  9, 0, 32'h0000_000a, 0);
		add_row(OP_XOR, 11, 10,  9, 0, 32'h0000_001e, 0);
		add_row(OP_OR,  12, 11,  3, 0, 32'h0001_123f, 0);
		add_row(OP_LDI, 13,  0,  0, 16'h0100, 32'h0000_0100, 1); // 16 with retire held
		add_row(OP_ADD, 14, 13,  1, 0, 32'h0000_1334, 1);
		add_row(OP_ADD, 13, 13, 13, 0, 32'h0000_0200, 1);
		add_row(OP_SUB, 15, 13, 14, 0, 32'hffff_eecc, 1);
		add_row(OP_XOR, 16, 15,  2, 0, 32'hffff_1133, 1);
		add_row(OP_AND, 17, 16,  4, 0, 32'hffff_1031, 1);
		add_row(OP_LDI, 18,  0,  0, 16'habcd, 32'h0000_abcd, 1);
		add_row(OP_OR,  19, 18, 13, 0, 32'h0000_abcd, 1);
		add_row(OP_ADD, 20, 19, 19, 0, 32'h0001_579a, 1);
		add_row(OP_LDI, 21,  0,  0, 16'h0001, 32'h0000_0001, 1);
		add_row(OP_SUB, 22,  0, 21, 0, 32'hffff_ffff, 1);
		add_row(OP_ADD, 23, 22, 21, 0, 32'h0000_0000, 1);
		add_row(OP_ADD, 24, 22, 22, 0, 32'hffff_fffe, 1);
		add_row(OP_XOR, 25, 24, 22, 0, 32'h0000_0001, 1);
		add_row(OP_LDI, 26,  0,  0, 16'h7777, 32'h0000_7777, 1);
		add_row(OP_ADD, 27, 26, 25, 0, 32'h0000_7778, 1);
		add_row(OP_LDI, 31,  0,  0, 16'h5555, 32'h0000_0000, 1); // r31 dest with the list empty
		add_row(OP_ADD, 31,  1,  2, 0, 32'h0000_0000, 1);
		add_row(OP_ADD, 28, 31,  1, 0, 32'h0000_1234, 0);        // r31 still reads zero
		add_row(OP_OR,  29, 31, 31, 0, 32'h0000_0000, 0);
		add_row(OP_SUB, 30,  2, 31, 0, 32'h0000_ffff, 0);
		add_row(OP_ADD,  1,  1, 27, 0, 32'h0000_89ac, 0);        // random tail
		add_row(OP_XOR,  2,  1, 20, 0, 32'h0001_de36, 0);
		add_row(OP_SUB,  3,  2,  1, 0, 32'h0001_548a, 0);
		add_row(OP_AND,  4,  3,  2, 0, 32'h0001_5402, 0);
		add_row(OP_LDI, 31,  0,  0, 16'h1111, 32'h0000_0000, 0);
		add_row(OP_OR,   5,  4, 21, 0, 32'h0001_5403, 0);
		add_row(OP_ADD,  6,  5,  5, 0, 32'h0002_a806, 0);

		repeat (16) @(posedge clk);
		#2;
		rst_n_i = 1'b1;

		@(negedge clk); // idle state after reset
		assert (in_ready_o) else begin
			$display("[FAIL] %0t ns in_ready_o: got %b expected 1", $time, in_ready_o);
			value_errors++;
		end
		assert (!retire_valid_o) else begin
			$display("[FAIL] %0t ns retire_valid_o: got %b expected 0", $time, retire_valid_o);
			value_errors++;
		end
		@(posedge clk);
		#2;

		for (int i = 0; i < row_op.size(); i++) begin
			// drain before the held block so all free tags are back
			if (row_stall[i] && (i == 0 || !row_stall[i-1])) begin
				wait_retired(i);
				hold_retire = 1'b1;
				@(posedge clk);
				#2;
			end
			if (row_stall[i] && i > 0 && row_stall[i-1] &&
				row_dest[i] == areg_t'(ZERO_REG) && row_dest[i-1] != areg_t'(ZERO_REG)) begin
				check_full_stop(i - FREE_NUM);
			end
			if (!row_stall[i] && i > 0 && row_stall[i-1]) begin
				@(negedge clk);
				hold_retire = 1'b0;
				@(posedge clk);
				#2;
			end
			offer_row(i);
		end

		wait_retired(row_op.size());
		repeat (4) @(negedge clk);
		assert (!retire_valid_o) else begin
			$display("[FAIL] %0t ns retire_valid_o: got %b expected 0", $time, retire_valid_o);
			value_errors++;
		end

		$display("summary: %0d value errors, %0d other errors, %0d of %0d rows retired",
			value_errors, other_errors, n_retired, row_op.size());
		if (value_errors == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule : rename_core_tb
